// ==== logic/dmm_pkg.sv ====
// shared types for the dmm core; register map is fixed at 7-bit addresses, frames are 8 + REG_W bits

package dmm_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int REG_W   = 32;  // spi register width
  localparam int COUNT_W = 24;  // precharge and aperture counters

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;  // low byte of status, lets host check the link

  //////////////////////////////////////////////////
  // register map

  typedef enum logic [6:0] {
    ADDR_STATUS    = 7'd0,  // read only
    ADDR_MODE      = 7'd1,
    ADDR_DIRECT    = 7'd2,
    ADDR_APERTURE  = 7'd3,  // mock adc aperture, clocks
    ADDR_PRECHARGE = 7'd4,  // precharge phase, clocks
    ADDR_SEQ_N     = 7'd5,  // entries minus one
    ADDR_SEQ0      = 7'd6,
    ADDR_SEQ1      = 7'd7,
    ADDR_SEQ2      = 7'd8,
    ADDR_SEQ3      = 7'd9
  } reg_addr_e;

  // output mode select
  // 4, 6 and 7 are kept for host software but only drive zeros
  typedef enum logic [2:0] {
    MODE_DIRECT      = 3'd0,
    MODE_LO          = 3'd1,
    MODE_HI          = 3'd2,
    MODE_PATTERN     = 3'd3,
    MODE_PC_TEST     = 3'd4,
    MODE_AZ_TEST     = 3'd5,
    MODE_REFMUX_TEST = 3'd6,
    MODE_ADC         = 3'd7
  } output_mode_e;

  typedef enum logic [1:0] {
    SEQ_IDLE      = 2'd0,
    SEQ_PRECHARGE = 2'd1,
    SEQ_SAMPLE    = 2'd2
  } seq_state_e;

  // one sequence step, low six bits of a SEQ register
  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;
  } seq_entry_t;

  // board outputs, msb first; direct register maps onto this bit for bit
  typedef struct packed {
    logic       meas_complete;
    logic       spi_interrupt;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_bus_t;

endpackage

// ==== logic/spi_register_set.sv ====
// spi slave sampled on clk_i, needs sck at or below clk_i/8; only exact 8+REG_W bit frames write
`timescale 1ns/100ps

module spi_register_set
  import dmm_pkg::*;
#(
  parameter int REG_W   = dmm_pkg::REG_W,
  parameter int COUNT_W = dmm_pkg::COUNT_W
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              sck_i,
  input  logic              ss_i,        // active low
  input  logic              sdi_i,
  input  logic [3:0]        hw_flags_i,
  output logic              sdo_o,
  output output_mode_e      mode_o,
  output logic [REG_W-1:0]  direct_o,
  output logic [COUNT_W-1:0] aperture_o,
  output logic [COUNT_W-1:0] precharge_o,
  output logic [1:0]        seq_n_o,
  output seq_entry_t [3:0]  seq_o
);

  localparam int ADDR_W  = 7;
  localparam int FRAME_W = 1 + ADDR_W + REG_W;      // write flag, address, data
  localparam int CNT_W   = $clog2(FRAME_W + 1) + 1; // headroom so long frames saturate past FRAME_W

  logic [2:0]         sck_q;    // two sync stages plus one for edge detect
  logic [2:0]         ss_q;
  logic [1:0]         sdi_q;
  logic [3:0]         hw_q;     // status flags, sampled every clock
  logic [3:0]         hw_qq;
  logic [CNT_W-1:0]   bit_cnt_q;
  logic [FRAME_W-1:0] rx_q;     // incoming frame
  logic [REG_W-1:0]   tx_q;     // readback shifter
  logic [REG_W-1:0]   rd_data;
  logic [ADDR_W-1:0]  rd_addr;
  logic [ADDR_W-1:0]  wr_addr;
  logic [REG_W-1:0]   wr_data;
  logic               active, sck_rise, sck_fall, ss_fall, ss_rise;

  assign active   = ~ss_q[1];
  assign sck_rise =  sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] &  sck_q[2];
  assign ss_fall  = ~ss_q[1]  &  ss_q[2];
  assign ss_rise  =  ss_q[1]  & ~ss_q[2];

  assign rd_addr = {rx_q[ADDR_W-2:0], sdi_q[1]};  // address complete as its last bit arrives
  assign wr_addr = rx_q[FRAME_W-2 -: ADDR_W];
  assign wr_data = rx_q[REG_W-1:0];

  //////////////////////////////////////////////////
  // pin sync

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_q <= '0;
      ss_q  <= '1;   // deselected, no false frame start out of reset
      sdi_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  always_ff @(posedge clk_i) begin
    hw_q  <= hw_flags_i;
    hw_qq <= hw_q;
  end

  //////////////////////////////////////////////////
  // readback mux

  always_comb begin
    rd_data = '0;  // unknown address reads zero
    case (rd_addr)
      ADDR_STATUS: begin
        rd_data[11:8] = hw_qq;
        rd_data[7:0]  = STATUS_MAGIC;
      end
      ADDR_MODE:      rd_data[2:0]         = mode_o;
      ADDR_DIRECT:    rd_data              = direct_o;
      ADDR_APERTURE:  rd_data[COUNT_W-1:0] = aperture_o;
      ADDR_PRECHARGE: rd_data[COUNT_W-1:0] = precharge_o;
      ADDR_SEQ_N:     rd_data[1:0]         = seq_n_o;
      ADDR_SEQ0:      rd_data[5:0]         = seq_o[0];
      ADDR_SEQ1:      rd_data[5:0]         = seq_o[1];
      ADDR_SEQ2:      rd_data[5:0]         = seq_o[2];
      ADDR_SEQ3:      rd_data[5:0]         = seq_o[3];
      default:        rd_data              = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // frame shifting

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
      sdo_o     <= 1'b0;
    end else if (ss_fall) begin
      bit_cnt_q <= '0;    // new frame
      sdo_o     <= 1'b0;
    end else if (active) begin
      if (sck_rise && bit_cnt_q != '1)
        bit_cnt_q <= bit_cnt_q + 1'b1;
      if (sck_fall) begin
        if (bit_cnt_q >= CNT_W'(ADDR_W + 1) && bit_cnt_q < CNT_W'(FRAME_W))
          sdo_o <= tx_q[REG_W-1];   // data phase, msb first
        else
          sdo_o <= 1'b0;            // address byte and overrun
      end
    end
  end

  // payload shifters, no reset needed
  always_ff @(posedge clk_i) begin
    if (active && sck_rise) begin
      rx_q <= {rx_q[FRAME_W-2:0], sdi_q[1]};
      if (bit_cnt_q == CNT_W'(ADDR_W))
        tx_q <= rd_data;           // latch on last address bit
    end else if (active && sck_fall && bit_cnt_q > CNT_W'(ADDR_W)) begin
      tx_q <= {tx_q[REG_W-2:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // register bank, commit on ss rise

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mode_o      <= MODE_DIRECT;
      direct_o    <= '0;
      aperture_o  <= '0;
      precharge_o <= '0;
      seq_n_o     <= '0;
      seq_o       <= '0;
    end else if (ss_rise && bit_cnt_q == CNT_W'(FRAME_W) && rx_q[FRAME_W-1]) begin
      case (wr_addr)
        ADDR_MODE:      mode_o      <= output_mode_e'(wr_data[2:0]);
        ADDR_DIRECT:    direct_o    <= wr_data;
        ADDR_APERTURE:  aperture_o  <= wr_data[COUNT_W-1:0];
        ADDR_PRECHARGE: precharge_o <= wr_data[COUNT_W-1:0];
        ADDR_SEQ_N:     seq_n_o     <= wr_data[1:0];
        ADDR_SEQ0:      seq_o[0]    <= wr_data[5:0];
        ADDR_SEQ1:      seq_o[1]    <= wr_data[5:0];
        ADDR_SEQ2:      seq_o[2]    <= wr_data[5:0];
        ADDR_SEQ3:      seq_o[3]    <= wr_data[5:0];
        default: ;  // status and unknown addresses ignored
      endcase
    end
  end

endmodule

// ==== logic/sequence_acquisition.sv ====
// auto-zero sequencer; run_i must already combine trigger and mode, precharge of 0 runs as 1 clock
`timescale 1ns/100ps

module sequence_acquisition
  import dmm_pkg::*;
#(
  parameter int COUNT_W         = dmm_pkg::COUNT_W,
  parameter int SEQ_MAX_ENTRIES = 4,
  localparam int IDX_W          = $clog2(SEQ_MAX_ENTRIES)
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             run_i,
  input  logic [IDX_W-1:0]                 seq_n_i,     // last entry index
  input  seq_entry_t [SEQ_MAX_ENTRIES-1:0] seq_i,
  input  logic [COUNT_W-1:0]               precharge_i,
  input  logic                             measure_valid_i,
  output logic                             adc_start_o,
  output out_bus_t                         bus_o
);

  seq_state_e         state_q;
  logic [COUNT_W-1:0] pc_cnt_q;
  logic [COUNT_W-1:0] pc_load;
  logic [IDX_W-1:0]   idx_q;
  logic               done_q;   // measurement finished, one clock
  seq_entry_t         entry;

  assign pc_load = (precharge_i == '0) ? COUNT_W'(1) : precharge_i;
  assign entry   = seq_i[idx_q];

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= SEQ_IDLE;
      pc_cnt_q    <= '0;
      idx_q       <= '0;
      adc_start_o <= 1'b0;
      done_q      <= 1'b0;
    end else if (!run_i) begin
      state_q     <= SEQ_IDLE;   // trigger dropped or mode changed
      idx_q       <= '0;
      adc_start_o <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      adc_start_o <= 1'b0;
      done_q      <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          state_q  <= SEQ_PRECHARGE;
          pc_cnt_q <= pc_load;
        end
        SEQ_PRECHARGE: begin
          if (pc_cnt_q == COUNT_W'(1)) begin
            state_q     <= SEQ_SAMPLE;
            adc_start_o <= 1'b1;     // single start per sample phase
          end else begin
            pc_cnt_q <= pc_cnt_q - 1'b1;
          end
        end
        SEQ_SAMPLE: begin
          if (measure_valid_i) begin   // wait length set by the adc
            done_q   <= 1'b1;
            state_q  <= SEQ_PRECHARGE;
            pc_cnt_q <= pc_load;
            idx_q    <= (idx_q == seq_n_i) ? '0 : idx_q + 1'b1;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // az test output bus

  always_comb begin
    bus_o               = '0;
    bus_o.meas_complete = done_q;
    bus_o.spi_interrupt = done_q;     // host irq tracks completion
    bus_o.leds          = 4'b0001 << idx_q;
    bus_o.monitor[1:0]  = state_q;
    bus_o.monitor[3:2]  = 2'(idx_q);
    if (state_q != SEQ_IDLE)
      bus_o.azmux = entry.azmux;
    if (state_q == SEQ_SAMPLE)
      bus_o.pc_sw = entry.pc_sw;      // switches open while precharging
  end

endmodule

// ==== logic/adc_mock.sv ====
// stand-in adc for timing tests; no conversion, starts while busy are dropped, aperture 0 runs as 1
`timescale 1ns/100ps

module adc_mock
  import dmm_pkg::*;
#(
  parameter int COUNT_W = dmm_pkg::COUNT_W
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  logic [COUNT_W-1:0] aperture_i,
  output logic               measure_valid_o,
  output logic               busy_o
);

  logic [COUNT_W-1:0] cnt_q;

  // valid lands exactly aperture clocks after the start pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q           <= '0;
      busy_o          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (busy_o) begin
        if (cnt_q == COUNT_W'(1)) begin
          busy_o          <= 1'b0;
          measure_valid_o <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (start_i) begin
        cnt_q  <= (aperture_i == '0) ? COUNT_W'(1) : aperture_i;
        busy_o <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/output_mode_mux.sv ====
// output select per mode, registered so pins lag their source by one clock; codes 4, 6, 7 give zeros
`timescale 1ns/100ps

module output_mode_mux
  import dmm_pkg::*;
#(
  parameter int REG_W = dmm_pkg::REG_W
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  output_mode_e     mode_i,
  input  logic [REG_W-1:0] direct_i,
  input  out_bus_t         az_bus_i,
  input  logic             adc_busy_i,
  output out_bus_t         bus_o
);

  localparam int BUS_W = $bits(out_bus_t);

  logic [REG_W-1:0] pat_cnt_q;  // free running test pattern
  out_bus_t         bus_d;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      pat_cnt_q <= '0;
    else
      pat_cnt_q <= pat_cnt_q + 1'b1;
  end

  //////////////////////////////////////////////////
  // mode select

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  bus_d = out_bus_t'(direct_i[BUS_W-1:0]);
      MODE_LO:      bus_d = '0;
      MODE_HI:      bus_d = '1;
      MODE_PATTERN: bus_d = out_bus_t'(pat_cnt_q[BUS_W-1:0]);  // needs a running clock
      MODE_AZ_TEST: begin
        bus_d            = az_bus_i;
        bus_d.monitor[4] = adc_busy_i;   // aperture visible on scope
      end
      default:      bus_d = '0;          // reserved codes
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i)
      bus_o <= '0;
    else
      bus_o <= bus_d;
  end

endmodule

// ==== logic/dmm_top.sv ====
// dmm control core, single clock domain; sck at or below clk_i/8, trigger_i taken as a raw level
`timescale 1ns/100ps

module dmm_top
  import dmm_pkg::*;
#(
  parameter int REG_W           = dmm_pkg::REG_W,
  parameter int COUNT_W         = dmm_pkg::COUNT_W,
  parameter int SEQ_MAX_ENTRIES = 4
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic [3:0] hw_flags_i,
  input  logic       trigger_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       spi_interrupt_o,
  output logic       meas_complete_o
);

  output_mode_e       mode;
  logic [REG_W-1:0]   direct;
  logic [COUNT_W-1:0] aperture;
  logic [COUNT_W-1:0] precharge;
  logic [1:0]         seq_n;
  seq_entry_t [3:0]   seq;
  logic               run;
  logic               adc_start, adc_valid, adc_busy;
  out_bus_t           az_bus;
  out_bus_t           out_bus;

  assign run = trigger_i && (mode == MODE_AZ_TEST);  // sequencer only in az test

  //////////////////////////////////////////////////
  // host registers

  spi_register_set #(.REG_W(REG_W), .COUNT_W(COUNT_W)) u_regs (
    .clk_i, .rst_i, .sck_i, .ss_i, .sdi_i, .hw_flags_i, .sdo_o,
    .mode_o(mode), .direct_o(direct), .aperture_o(aperture),
    .precharge_o(precharge), .seq_n_o(seq_n), .seq_o(seq)
  );

  //////////////////////////////////////////////////
  // az sequence with mocked adc

  sequence_acquisition #(.COUNT_W(COUNT_W), .SEQ_MAX_ENTRIES(SEQ_MAX_ENTRIES)) u_seq (
    .clk_i, .rst_i, .run_i(run), .seq_n_i(seq_n), .seq_i(seq),
    .precharge_i(precharge), .measure_valid_i(adc_valid),
    .adc_start_o(adc_start), .bus_o(az_bus)
  );

  adc_mock #(.COUNT_W(COUNT_W)) u_adc (
    .clk_i, .rst_i, .start_i(adc_start), .aperture_i(aperture),
    .measure_valid_o(adc_valid), .busy_o(adc_busy)
  );

  output_mode_mux #(.REG_W(REG_W)) u_mux (
    .clk_i, .rst_i, .mode_i(mode), .direct_i(direct), .az_bus_i(az_bus),
    .adc_busy_i(adc_busy), .bus_o(out_bus)
  );

  // pins
  assign meas_complete_o = out_bus.meas_complete;
  assign spi_interrupt_o = out_bus.spi_interrupt;
  assign azmux_o         = out_bus.azmux;
  assign pc_sw_o         = out_bus.pc_sw;
  assign monitor_o       = out_bus.monitor;
  assign leds_o          = out_bus.leds;

endmodule

// ==== test/dmm_checker.sv ====
// samples dmm_top pins on falling clk edges; read checks assume 40-bit frames, az checks need az_chk_i
`timescale 1ns/100ps

module dmm_checker
  import dmm_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             sck_i,
  input  logic             ss_i,
  input  logic             sdi_i,
  input  logic             sdo_i,
  input  logic             trigger_i,
  input  out_bus_t         pins_i,      // dut outputs regrouped
  input  logic [31:0]      rd_exp_i,    // expected data of the next read frame
  input  out_bus_t         pins_exp_i,
  input  logic             pins_chk_i,  // compare pins every clock
  input  logic             pat_chk_i,   // pattern counter must step by one
  input  logic             az_chk_i,
  input  seq_entry_t [3:0] az_seq_i,
  input  logic [1:0]       az_last_i,   // seq_n
  input  int               az_gap_i,    // shortest legal pulse spacing
  output int               errors_o,
  output int               pulses_o
);

  logic        sck_d = 1'b0;
  logic        ss_d  = 1'b1;
  int          bit_cnt;
  logic [39:0] sdi_sh;    // host side of the frame
  logic [39:0] sdo_sh;    // slave side, reassembled
  logic [11:0] pat_prev;
  logic        pat_valid;
  int          gap;       // clocks since last pulse
  int          trig_low;  // clocks with trigger low
  logic [1:0]  exp_idx;
  logic        first;     // no spacing check on the first pulse of a run

  initial begin
    errors_o = 0;
    pulses_o = 0;
  end

  task automatic report_error(input string msg);
    errors_o = errors_o + 1;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      bit_cnt   = 0;
      pat_valid = 1'b0;
      first     = 1'b1;
      exp_idx   = 2'd0;
      gap       = 0;
      trig_low  = 0;
    end else begin
      //////////////////////////////////////////////////
      // spi frames
      if (ss_d && !ss_i)
        bit_cnt = 0;
      if (!ss_i && sck_i && !sck_d) begin  // host samples on sck rise
        sdi_sh  = {sdi_sh[38:0], sdi_i};
        sdo_sh  = {sdo_sh[38:0], sdo_i};
        bit_cnt = bit_cnt + 1;
      end
      if (!ss_d && ss_i && bit_cnt == 40 && !sdi_sh[39]) begin
        if (sdo_sh[39:32] !== 8'h00)
          report_error("sdo not low during the address byte");
        if (sdo_sh[31:0] !== rd_exp_i)
          report_error($sformatf("read of address %0d returned %h, expected %h",
                                 sdi_sh[38:32], sdo_sh[31:0], rd_exp_i));
      end

      //////////////////////////////////////////////////
      // fixed modes and pattern
      if (pins_chk_i && pins_i !== pins_exp_i)
        report_error($sformatf("outputs %h, expected %h", pins_i, pins_exp_i));
      if (pat_chk_i) begin
        if (pat_valid && {pins_i.monitor, pins_i.leds} !== pat_prev + 12'd1)
          report_error($sformatf("pattern %h after %h", {pins_i.monitor, pins_i.leds}, pat_prev));
        pat_prev  = {pins_i.monitor, pins_i.leds};
        pat_valid = 1'b1;
      end else begin
        pat_valid = 1'b0;
      end

      //////////////////////////////////////////////////
      // az sequence
      gap = gap + 1;
      if (!trigger_i) begin
        trig_low = trig_low + 1;
        first    = 1'b1;
        exp_idx  = 2'd0;  // sequencer restarts at entry 0
      end else begin
        trig_low = 0;
      end
      if (az_chk_i) begin
        if (pins_i.spi_interrupt !== pins_i.meas_complete)
          report_error("spi_interrupt and meas_complete differ");
        if (trig_low > 4 && pins_i.meas_complete)
          report_error("meas_complete pulse after trigger dropped");
        if (trigger_i && pins_i.meas_complete) begin
          // index has already advanced when the pulse reaches the pins
          exp_idx = (exp_idx == az_last_i) ? 2'd0 : exp_idx + 2'd1;
          if (pins_i.azmux !== az_seq_i[exp_idx].azmux)
            report_error($sformatf("azmux %h, expected entry %0d %h",
                                   pins_i.azmux, exp_idx, az_seq_i[exp_idx].azmux));
          if (pins_i.leds !== 4'b0001 << exp_idx)
            report_error($sformatf("leds %b, expected index %0d", pins_i.leds, exp_idx));
          if (!first && gap < az_gap_i)
            report_error($sformatf("pulse spacing %0d below %0d", gap, az_gap_i));
          first    = 1'b0;
          gap      = 0;
          pulses_o = pulses_o + 1;
        end
      end
    end
    sck_d = sck_i;
    ss_d  = ss_i;
  end

endmodule

// ==== test/tb_dmm_top.sv ====
// testbench for dmm_top; sck at clk/8, az rows need small precharge and aperture to finish in time
`timescale 1ns/100ps

module tb_dmm_top
  import dmm_pkg::*;
();

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_SHORT, OP_MODE, OP_RUN} op_e;

  typedef struct packed {
    op_e         op;
    logic [6:0]  addr;
    logic [31:0] data;   // mode code or trigger level for OP_MODE and OP_RUN
    logic        rnd;    // replace data by an lfsr word
    logic [3:0]  flags;  // hw_flags_i during the row
  } row_t;

  logic             clk_i;
  logic             rst_i    = 1'b1;
  logic             sck      = 1'b0;
  logic             ss       = 1'b1;  // deselected
  logic             sdi      = 1'b0;
  logic [3:0]       hw_flags = 4'h0;
  logic             trigger  = 1'b0;
  logic             sdo;
  logic [3:0]       leds;
  logic [3:0]       azmux;
  logic [7:0]       monitor;
  logic [1:0]       pc_sw;
  logic             spi_irq;
  logic             meas_done;
  out_bus_t         pins;
  logic [31:0]      rd_exp   = '0;
  out_bus_t         pins_exp = '0;
  logic             pins_chk = 1'b0;
  logic             pat_chk  = 1'b0;
  logic             az_chk   = 1'b0;
  seq_entry_t [3:0] az_seq   = '0;
  logic [1:0]       az_last  = '0;
  int               az_gap   = 0;
  int               errors;
  int               pulses;
  int               timeouts = 0;
  logic [15:0]      lfsr     = 16'd11109;
  logic [31:0]      shadow [0:127];      // expected register bank
  row_t             rows [$];

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  dmm_top dut0 (
    .clk_i, .rst_i, .sck_i(sck), .ss_i(ss), .sdi_i(sdi), .sdo_o(sdo),
    .hw_flags_i(hw_flags), .trigger_i(trigger),
    .leds_o(leds), .monitor_o(monitor), .pc_sw_o(pc_sw), .azmux_o(azmux),
    .spi_interrupt_o(spi_irq), .meas_complete_o(meas_done)
  );

  assign pins = {meas_done, spi_irq, azmux, pc_sw, monitor, leds};

  dmm_checker chk0 (
    .clk_i, .rst_i, .sck_i(sck), .ss_i(ss), .sdi_i(sdi), .sdo_i(sdo), .trigger_i(trigger),
    .pins_i(pins), .rd_exp_i(rd_exp), .pins_exp_i(pins_exp), .pins_chk_i(pins_chk),
    .pat_chk_i(pat_chk), .az_chk_i(az_chk), .az_seq_i(az_seq), .az_last_i(az_last),
    .az_gap_i(az_gap), .errors_o(errors), .pulses_o(pulses)
  );

  //////////////////////////////////////////////////
  // models

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  // bits a write can reach, zero for status and unknown addresses
  function automatic logic [31:0] write_mask(input logic [6:0] a);
    case (a)
      ADDR_MODE:                                  return 32'h0000_0007;
      ADDR_DIRECT:                                return 32'hffff_ffff;
      ADDR_APERTURE, ADDR_PRECHARGE:              return 32'h00ff_ffff;
      ADDR_SEQ_N:                                 return 32'h0000_0003;
      ADDR_SEQ0, ADDR_SEQ1, ADDR_SEQ2, ADDR_SEQ3: return 32'h0000_003f;
      default:                                    return 32'h0000_0000;
    endcase
  endfunction

  function automatic int at_least_one(input logic [31:0] v);
    return (v == 32'd0) ? 1 : int'(v);
  endfunction

  function automatic out_bus_t expected_bus(input output_mode_e m);
    out_bus_t b;
    b = '0;                   // lo and the reserved codes
    case (m)
      MODE_DIRECT:  b = out_bus_t'(shadow[ADDR_DIRECT][19:0]);
      MODE_HI:      b = '1;
      MODE_AZ_TEST: b.leds = 4'b0001;  // sequencer idle at index 0
      default:      b = '0;
    endcase
    return b;
  endfunction

  //////////////////////////////////////////////////
  // spi host

  task automatic spi_frame(input logic wr, input logic [6:0] addr, input logic [31:0] data,
                           input int nbits);
    logic [39:0] frame;
    frame = {wr, addr, data};
    @(posedge clk_i) ss <= 1'b0;
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < nbits; i++) begin
      sdi <= frame[39-i];   // set up while sck low
      sck <= 1'b0;
      repeat (4) @(posedge clk_i);
      sck <= 1'b1;
      repeat (4) @(posedge clk_i);
    end
    sck <= 1'b0;
    repeat (4) @(posedge clk_i);
    ss <= 1'b1;
    repeat (8) @(posedge clk_i);  // commit and output register
  endtask

  task automatic write_reg(input logic [6:0] a, input logic [31:0] d);
    spi_frame(1'b1, a, d, 40);
    shadow[a] = d & write_mask(a);
  endtask

  //////////////////////////////////////////////////
  // row actions

  task automatic set_mode(input output_mode_e m);
    out_bus_t    exp;
    logic [11:0] last;
    logic        settled;
    int          n;
    write_reg(ADDR_MODE, {29'd0, m});
    exp     = expected_bus(m);
    settled = 1'b0;
    n       = 0;
    last    = {pins.monitor, pins.leds};
    while (n < 32 && !settled) begin
      @(negedge clk_i);
      if (m == MODE_PATTERN)
        settled = ({pins.monitor, pins.leds} == last + 12'd1);
      else
        settled = (pins === exp);
      last = {pins.monitor, pins.leds};
      n    = n + 1;
    end
    if (!settled) begin
      timeouts = timeouts + 1;
      $display("timed out waiting for the outputs to settle in mode %0d", m);
    end else begin
      @(posedge clk_i);
      pins_exp <= exp;
      pins_chk <= (m != MODE_PATTERN);
      pat_chk  <= (m == MODE_PATTERN);
      repeat (24) @(posedge clk_i);
      pins_chk <= 1'b0;
      pat_chk  <= 1'b0;
    end
  endtask

  task automatic run_trigger(input logic level);
    int start;
    int n;
    if (level) begin
      az_seq  <= {shadow[ADDR_SEQ3][5:0], shadow[ADDR_SEQ2][5:0],
                  shadow[ADDR_SEQ1][5:0], shadow[ADDR_SEQ0][5:0]};
      az_last <= shadow[ADDR_SEQ_N][1:0];
      az_gap  <= at_least_one(shadow[ADDR_PRECHARGE]) + at_least_one(shadow[ADDR_APERTURE]);
      az_chk  <= 1'b1;
      trigger <= 1'b1;
      start    = pulses;
      n        = 0;
      while (n < 4000 && pulses < start + 7) begin
        @(posedge clk_i);
        n = n + 1;
      end
      if (pulses < start + 7) begin
        timeouts = timeouts + 1;
        $display("timed out waiting for meas_complete pulses in the az test");
      end
    end else begin
      trigger <= 1'b0;
      repeat (200) @(posedge clk_i);  // quiet window, checker flags any pulse
      az_chk <= 1'b0;
    end
  endtask

  task automatic add_row(input op_e op, input logic [6:0] addr, input logic [31:0] data,
                         input logic rnd, input logic [3:0] flags);
    rows.push_back({op, addr, data, rnd, flags});
  endtask

  task automatic build_rows();
    add_row(OP_MODE, ADDR_MODE, MODE_DIRECT, 1'b0, 4'h0);  // all low out of reset
    for (int a = 6; a <= 9; a++) begin
      add_row(OP_WRITE, 7'(a), 32'd0, 1'b1, 4'h0);
      add_row(OP_READ, 7'(a), 32'd0, 1'b0, 4'h0);
    end
    for (int a = 2; a <= 4; a++) begin
      add_row(OP_WRITE, 7'(a), 32'd0, 1'b1, 4'h0);
      add_row(OP_READ, 7'(a), 32'd0, 1'b0, 4'h0);
    end
    add_row(OP_READ, 7'h0a, 32'd0, 1'b0, 4'h0);
    add_row(OP_READ, 7'h7f, 32'd0, 1'b0, 4'h0);
    add_row(OP_READ, ADDR_STATUS, 32'd0, 1'b0, 4'h5);
    add_row(OP_WRITE, ADDR_STATUS, 32'd0, 1'b1, 4'h5);
    add_row(OP_READ, ADDR_STATUS, 32'd0, 1'b0, 4'hc);
    add_row(OP_SHORT, ADDR_DIRECT, 32'd0, 1'b1, 4'h0);
    add_row(OP_READ, ADDR_DIRECT, 32'd0, 1'b0, 4'h0);
    for (int m = 0; m < 8; m++) begin
      if (m != 5)
        add_row(OP_MODE, ADDR_MODE, 32'(m), 1'b0, 4'h0);
    end
    add_row(OP_WRITE, ADDR_PRECHARGE, 32'd5, 1'b0, 4'h0);
    add_row(OP_WRITE, ADDR_APERTURE, 32'd12, 1'b0, 4'h0);
    add_row(OP_WRITE, ADDR_SEQ_N, 32'd2, 1'b0, 4'h0);
    add_row(OP_MODE, ADDR_MODE, MODE_AZ_TEST, 1'b0, 4'h0);
    add_row(OP_RUN, 7'd0, 32'd1, 1'b0, 4'h0);
    add_row(OP_RUN, 7'd0, 32'd0, 1'b0, 4'h0);
    add_row(OP_RUN, 7'd0, 32'd1, 1'b0, 4'h0);  // restart from entry 0
    add_row(OP_RUN, 7'd0, 32'd0, 1'b0, 4'h0);
  endtask

  //////////////////////////////////////////////////
  // main

  initial begin
    row_t        row;
    logic [31:0] data;
    for (int a = 0; a < 128; a++)
      shadow[a] = 32'd0;             // matches the reset values
    build_rows();
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      row  = rows[i];
      data = row.data;
      if (row.rnd)
        random_word(data);
      @(posedge clk_i) hw_flags <= row.flags;
      case (row.op)
        OP_WRITE: write_reg(row.addr, data);
        OP_SHORT: spi_frame(1'b1, row.addr, data, 39);  // one bit short, must be dropped
        OP_READ: begin
          if (row.addr == ADDR_STATUS)
            rd_exp <= {20'd0, row.flags, 8'hAA};
          else
            rd_exp <= shadow[row.addr];
          spi_frame(1'b0, row.addr, 32'd0, 40);
        end
        OP_MODE:  set_mode(output_mode_e'(data[2:0]));
        default:  run_trigger(data[0]);
      endcase
    end
    repeat (4) @(posedge clk_i);
    $display("checker errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== sources.f ====
logic/dmm_pkg.sv
logic/spi_register_set.sv
logic/sequence_acquisition.sv
logic/adc_mock.sv
logic/output_mode_mux.sv
logic/dmm_top.sv
test/dmm_checker.sv
test/tb_dmm_top.sv

// ==== Bender.yml ====
package:
  name: dmm_core

sources:
  - logic/dmm_pkg.sv
  - logic/spi_register_set.sv
  - logic/sequence_acquisition.sv
  - logic/adc_mock.sv
  - logic/output_mode_mux.sv
  - logic/dmm_top.sv
  - target: test
    files:
      - test/dmm_checker.sv
      - test/tb_dmm_top.sv
